// File: include/gfx_macros.svh
// ##########################################################
// Shared constants for the graphics host. Include wherever
// geometry, seeds, credits or the trigger key are needed
// ##########################################################
`ifndef GFX_MACROS_SVH
`define GFX_MACROS_SVH

// Frame-buffer geometry
`define GFX_FB_COLS       32
`define GFX_FB_ROWS       32
`define GFX_FB_AW         10

// Scanned raster, a subset of the buffer rows
`define GFX_SCAN_COLS     32
`define GFX_SCAN_ROWS     24

// Palette depth and reset seeds
`define GFX_PAL_DEPTH     256
`define GFX_PAL_SEED      24'hADBEEF
`define GFX_FB_SEED       32'hDEADBEEF

// Pattern generator
`define GFX_LFSR_W        160
`define GFX_PATTERN       160'hFEDCBA9876543210ABCDEF0123456789DEADBEEF

// Display stream credits granted after reset
`define GFX_DISP_CREDITS  4

// Trigger value on the low 16 pattern bits
`define GFX_TROJ_KEY      16'hFBBC

`endif

// File: design/gfx_pkg.sv
// ##########################################################
// Common types for the graphics host. Referenced by scoped
// name from the interface and the RTL blocks
// ##########################################################
package gfx_pkg;

    // 24-bit RGB colour as sent on the display stream
    typedef logic [23:0] color_t;

    // Pixel and scan coordinate
    typedef logic [15:0] coord_t;

    // One frame-buffer word
    // Write side stores it whole, colorizer splits off the index
    typedef union packed {
        logic [31:0] raw;          // Full word as written
        struct packed {
            logic [23:0] tag;      // Upper bits, not displayed
            logic [7:0]  idx;      // Palette index
        } fields;
    } fb_word_u;

endpackage

// File: design/gfx_if.sv
// ##########################################################
// Frame-buffer port bundle. The scanner reads through it and
// the memory serves both the write and the read side
// ##########################################################
`timescale 1ns/100ps
`include "gfx_macros.svh"

interface fb_if;

    // Write side
    logic                   wr_en;
    logic [`GFX_FB_AW-1:0]  wr_addr;
    gfx_pkg::fb_word_u      wr_data;

    // Read side, data valid one cycle after rd_en
    logic                   rd_en;
    logic [`GFX_FB_AW-1:0]  rd_addr;
    gfx_pkg::fb_word_u      rd_data;

    // Observer of write traffic
    modport write (
        input wr_en,
        input wr_addr,
        input wr_data
    );

    // Read requester and data consumer
    modport read (
        output rd_en,
        output rd_addr,
        input  rd_data
    );

    // Memory decodes its own write port and answers reads
    modport mem (
        output wr_en,
        output wr_addr,
        output wr_data,
        input  rd_en,
        input  rd_addr,
        output rd_data
    );

endinterface

// File: design/pattern_lfsr.sv
// ##########################################################
// 160-bit pattern generator. Advances one position for each
// cycle with host activity on step_i
// ##########################################################
`timescale 1ns/100ps
`include "gfx_macros.svh"

module pattern_lfsr (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    step_i,
    output logic [`GFX_LFSR_W-1:0]  pattern_o
);

    logic [`GFX_LFSR_W-1:0] lfsr_q;
    logic                   feedback;

    // Taps at 159, 127, 95 and 63
    assign feedback = lfsr_q[159] ^ lfsr_q[127] ^ lfsr_q[95] ^ lfsr_q[63];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr_q <= `GFX_PATTERN;
        end else if (step_i) begin
            lfsr_q <= {lfsr_q[`GFX_LFSR_W-2:0], feedback};  // Shift toward MSB
        end
    end

    assign pattern_o = lfsr_q;

endmodule

// File: design/frame_buffer.sv
// ##########################################################
// 1024-word frame buffer. Pixel writes are addressed by x and
// y, reads come from the scanner with one cycle of latency
// ##########################################################
`timescale 1ns/100ps
`include "gfx_macros.svh"

module frame_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic [31:0]       pixel_data_i,
    input  gfx_pkg::coord_t   pixel_x_i,
    input  gfx_pkg::coord_t   pixel_y_i,
    input  logic              pixel_write_i,
    fb_if.mem                 fb
);

    localparam int DEPTH = `GFX_FB_COLS * `GFX_FB_ROWS;
    localparam int XW    = $clog2(`GFX_FB_COLS);
    localparam int YW    = `GFX_FB_AW - XW;

    gfx_pkg::fb_word_u mem [0:DEPTH-1];

    // Row-major address, y times 32 plus x
    assign fb.wr_en    = pixel_write_i;
    assign fb.wr_addr  = {pixel_y_i[YW-1:0], pixel_x_i[XW-1:0]};
    assign fb.wr_data.raw = pixel_data_i;

    // Storage with seeded contents after reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int p = 0; p < DEPTH; p++) begin
                mem[p].raw <= `GFX_FB_SEED + 32'(p);
            end
        end else if (fb.wr_en) begin
            mem[fb.wr_addr] <= fb.wr_data;
        end
    end

    // Registered read
    // Same-cycle write to the same word returns the old data
    always_ff @(posedge clk) begin
        if (fb.rd_en) begin
            fb.rd_data <= mem[fb.rd_addr];
        end
    end

endmodule

// File: design/raster_scan.sv
// ##########################################################
// Raster scanner. Walks 32 columns by 24 rows after a frame
// start and issues one read per available display credit
// ##########################################################
`timescale 1ns/100ps
`include "gfx_macros.svh"

module raster_scan (
    input  logic              clk,
    input  logic              rst,
    input  logic              frame_start_i,
    input  logic              display_credit_i,
    fb_if.read                fb,
    output gfx_pkg::coord_t   scan_x_o,
    output gfx_pkg::coord_t   scan_y_o,
    output logic              issue_o,
    output logic              line_end_o,
    output logic              frame_end_o
);

    localparam int CW = $clog2(`GFX_DISP_CREDITS + 1);
    localparam int XW = $clog2(`GFX_FB_COLS);
    localparam int YW = `GFX_FB_AW - XW;

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_SCAN  = 2'd1;
    localparam logic [1:0] ST_DRAIN = 2'd2;

    logic [1:0]       state;
    logic             drain_cnt;    // Covers memory and palette stages
    logic [CW-1:0]    credits;
    gfx_pkg::coord_t  x_q;
    gfx_pkg::coord_t  y_q;
    logic             issue;
    logic             last_col;
    logic             last_row;

    assign last_col = (x_q == gfx_pkg::coord_t'(`GFX_SCAN_COLS - 1));
    assign last_row = (y_q == gfx_pkg::coord_t'(`GFX_SCAN_ROWS - 1));

    // One read per cycle while scanning and holding a credit
    assign issue = (state == ST_SCAN) && (credits != '0);

    assign fb.rd_en   = issue;
    assign fb.rd_addr = {y_q[YW-1:0], x_q[XW-1:0]};

    assign issue_o     = issue;
    assign scan_x_o    = x_q;
    assign scan_y_o    = y_q;
    assign line_end_o  = issue && last_col;
    assign frame_end_o = issue && last_col && last_row;

    // Credits leave with each read and come back from the sink
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= CW'(`GFX_DISP_CREDITS);
        end else begin
            credits <= credits - CW'(issue) + CW'(display_credit_i);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ST_IDLE;
            drain_cnt <= 1'b0;
            x_q       <= '0;
            y_q       <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (frame_start_i) begin   // Only accepted here
                        x_q   <= '0;
                        y_q   <= '0;
                        state <= ST_SCAN;
                    end
                end
                ST_SCAN: begin
                    if (issue) begin
                        if (last_col) begin
                            x_q <= '0;
                            if (last_row) begin
                                y_q       <= '0;
                                drain_cnt <= 1'b0;
                                state     <= ST_DRAIN;
                            end else begin
                                y_q <= y_q + 1'b1;
                            end
                        end else begin
                            x_q <= x_q + 1'b1;
                        end
                    end
                end
                ST_DRAIN: begin
                    // Wait out the last pixel in flight
                    if (drain_cnt) begin
                        state <= ST_IDLE;
                    end
                    drain_cnt <= 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: design/trojan_slave_select.sv
// ##########################################################
// Trojan benchmark block. Produces a 4-bit select that
// perturbs colours on diagonal pixels once the key matches
// ##########################################################
`timescale 1ns/100ps
`include "gfx_macros.svh"

module trojan_slave_select (
    input  gfx_pkg::coord_t         scan_x_i,
    input  gfx_pkg::coord_t         scan_y_i,
    input  logic [`GFX_LFSR_W-1:0]  pattern_i,
    output logic [3:0]              slv_sel_o
);

    logic key_hit;
    logic on_diag;

    // Trigger on the low pattern half-word
    assign key_hit = (pattern_i[15:0] == `GFX_TROJ_KEY);
    assign on_diag = (scan_x_i == scan_y_i);

    // Payload is the pattern's low nibble
    always_comb begin
        if (key_hit && on_diag) begin
            slv_sel_o = pattern_i[3:0];
        end else begin
            slv_sel_o = 4'h0;
        end
    end

endmodule

// File: design/palette_colorizer.sv
// ##########################################################
// Palette lookup and output stage. Turns frame-buffer words
// into colours and lines the sync flags up with the data
// ##########################################################
`timescale 1ns/100ps
`include "gfx_macros.svh"

module palette_colorizer (
    input  logic              clk,
    input  logic              rst,
    fb_if.read                fb,
    input  logic              issue_i,
    input  logic              line_end_i,
    input  logic              frame_end_i,
    input  logic [3:0]        slv_sel_i,
    output gfx_pkg::color_t   display_data_o,
    output logic              display_valid_o,
    output logic              hsync_o,
    output logic              vsync_o,
    output logic              frame_ready_o
);

    gfx_pkg::color_t palette [0:`GFX_PAL_DEPTH-1];

    logic       valid_d1;
    logic       line_d1;
    logic       frame_d1;
    logic [3:0] sel_d1;     // Aligned with rd_data

    // Fixed palette, entry i is seed plus i
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `GFX_PAL_DEPTH; i++) begin
                palette[i] <= `GFX_PAL_SEED + 24'(i);
            end
        end
    end

    // Stage 1 tracks the memory read, stage 2 the lookup
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_d1        <= 1'b0;
            line_d1         <= 1'b0;
            frame_d1        <= 1'b0;
            display_valid_o <= 1'b0;
            hsync_o         <= 1'b0;
            vsync_o         <= 1'b0;
            frame_ready_o   <= 1'b0;
        end else begin
            valid_d1        <= issue_i;
            line_d1         <= line_end_i;
            frame_d1        <= frame_end_i;
            display_valid_o <= valid_d1;
            hsync_o         <= line_d1;
            vsync_o         <= frame_d1;
            frame_ready_o   <= vsync_o;   // Cycle after the last pixel
        end
    end

    always_ff @(posedge clk) begin
        sel_d1 <= slv_sel_i;
        // Select bits land on the low nibble of the colour
        display_data_o <= palette[fb.rd_data.fields.idx] ^ gfx_pkg::color_t'(sel_d1);
    end

endmodule

// File: design/gfx_host_top.sv
// ##########################################################
// Graphics host top level. Pixel writes in, palette colours
// out on a credit-controlled display stream
// ##########################################################
`timescale 1ns/100ps
`include "gfx_macros.svh"

module gfx_host_top (
    input  logic              clk,
    input  logic              rst,
    input  logic [31:0]       pixel_data_i,
    input  gfx_pkg::coord_t   pixel_x_i,
    input  gfx_pkg::coord_t   pixel_y_i,
    input  logic              pixel_write_i,
    input  logic              frame_start_i,
    input  logic              display_credit_i,
    output gfx_pkg::color_t   display_data_o,
    output logic              display_valid_o,
    output logic              hsync_o,
    output logic              vsync_o,
    output logic              frame_ready_o
);

    gfx_pkg::coord_t          scan_x;
    gfx_pkg::coord_t          scan_y;
    logic                     issue;
    logic                     line_end;
    logic                     frame_end;
    logic                     lfsr_step;
    logic [`GFX_LFSR_W-1:0]   pattern;
    logic [3:0]               slv_sel;

    fb_if fb0 ();

    // Pattern advances on any host command
    assign lfsr_step = pixel_write_i | frame_start_i;

    pattern_lfsr lfsr0 (
        .clk       (clk),
        .rst       (rst),
        .step_i    (lfsr_step),
        .pattern_o (pattern)
    );

    frame_buffer fbuf0 (
        .clk           (clk),
        .rst           (rst),
        .pixel_data_i  (pixel_data_i),
        .pixel_x_i     (pixel_x_i),
        .pixel_y_i     (pixel_y_i),
        .pixel_write_i (pixel_write_i),
        .fb            (fb0.mem)
    );

    raster_scan scan0 (
        .clk              (clk),
        .rst              (rst),
        .frame_start_i    (frame_start_i),
        .display_credit_i (display_credit_i),
        .fb               (fb0.read),
        .scan_x_o         (scan_x),
        .scan_y_o         (scan_y),
        .issue_o          (issue),
        .line_end_o       (line_end),
        .frame_end_o      (frame_end)
    );

    trojan_slave_select troj0 (
        .scan_x_i  (scan_x),
        .scan_y_i  (scan_y),
        .pattern_i (pattern),
        .slv_sel_o (slv_sel)
    );

    palette_colorizer color0 (
        .clk             (clk),
        .rst             (rst),
        .fb              (fb0.read),     // rd_data only
        .issue_i         (issue),
        .line_end_i      (line_end),
        .frame_end_i     (frame_end),
        .slv_sel_i       (slv_sel),
        .display_data_o  (display_data_o),
        .display_valid_o (display_valid_o),
        .hsync_o         (hsync_o),
        .vsync_o         (vsync_o),
        .frame_ready_o   (frame_ready_o)
    );

endmodule

// File: verif/gfx_host_sva.sv
// ##########################################################
// Bound checks on the display stream. Tracks credits and
// pixels in flight and the order of the sync flags
// ##########################################################
`timescale 1ns/100ps
`include "gfx_macros.svh"

module gfx_host_sva (
    input logic clk,
    input logic rst,
    input logic issue_i,
    input logic credit_i,
    input logic valid_i,
    input logic hsync_i,
    input logic vsync_i,
    input logic frame_ready_i
);

    int in_use;       // Credits taken by reads, not yet returned
    int in_flight;    // Reads issued, pixel not yet out
    int sva_errors;

    initial sva_errors = 0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_use    <= 0;
            in_flight <= 0;
        end else begin
            in_use    <= in_use + int'(issue_i) - int'(credit_i);
            in_flight <= in_flight + int'(issue_i) - int'(valid_i);
        end
    end

    credit_limit: assert property (@(posedge clk) disable iff (rst)
        in_use <= `GFX_DISP_CREDITS)
        else begin $error("more credits in use than granted"); sva_errors++; end

    flight_limit: assert property (@(posedge clk) disable iff (rst)
        in_flight <= `GFX_DISP_CREDITS)
        else begin $error("too many pixels in flight"); sva_errors++; end

    // Every pixel comes from a read two cycles earlier
    valid_source: assert property (@(posedge clk) disable iff (rst)
        valid_i |-> $past(issue_i, 2))
        else begin $error("valid without a consumed credit"); sva_errors++; end

    credit_return: assert property (@(posedge clk) disable iff (rst)
        credit_i |-> (in_use + int'(issue_i)) > 0)
        else begin $error("credit returned that was never taken"); sva_errors++; end

    hsync_with_pixel: assert property (@(posedge clk) disable iff (rst)
        hsync_i |-> valid_i)
        else begin $error("hsync without its pixel"); sva_errors++; end

    vsync_with_hsync: assert property (@(posedge clk) disable iff (rst)
        vsync_i |-> hsync_i)
        else begin $error("vsync without line end"); sva_errors++; end

    ready_after_vsync: assert property (@(posedge clk) disable iff (rst)
        frame_ready_i |-> ($past(vsync_i) && !valid_i))
        else begin $error("frame ready out of place"); sva_errors++; end

endmodule

bind gfx_host_top gfx_host_sva sva0 (
    .clk           (clk),
    .rst           (rst),
    .issue_i       (issue),
    .credit_i      (display_credit_i),
    .valid_i       (display_valid_o),
    .hsync_i       (hsync_o),
    .vsync_i       (vsync_o),
    .frame_ready_i (frame_ready_o)
);

// File: verif/gfx_host_tb.sv
// ##########################################################
// Testbench for the graphics host. Replays the stimulus file,
// returns display credits after random delays, checks frames
// ##########################################################
`timescale 1ns/100ps
`include "gfx_macros.svh"

module gfx_host_tb;

    localparam int    PIXELS        = `GFX_SCAN_COLS * `GFX_SCAN_ROWS;
    localparam int    FRAME_TIMEOUT = 20000;
    localparam string STIM_FILE     = "verif/gfx_stimulus.txt";

    logic              clk;
    logic              rst;
    logic [31:0]       pixel_data_i;
    gfx_pkg::coord_t   pixel_x_i;
    gfx_pkg::coord_t   pixel_y_i;
    logic              pixel_write_i;
    logic              frame_start_i;
    logic              display_credit_i;
    gfx_pkg::color_t   display_data_o;
    logic              display_valid_o;
    logic              hsync_o;
    logic              vsync_o;
    logic              frame_ready_o;

    gfx_pkg::color_t   frame_pix [0:PIXELS-1];   // Last captured frame, row-major
    logic [15:0]       rng_state;
    int                value_errors;
    int                other_errors;
    int                frames_run;
    bit                timed_out;

    gfx_host_top dut0 (
        .clk              (clk),
        .rst              (rst),
        .pixel_data_i     (pixel_data_i),
        .pixel_x_i        (pixel_x_i),
        .pixel_y_i        (pixel_y_i),
        .pixel_write_i    (pixel_write_i),
        .frame_start_i    (frame_start_i),
        .display_credit_i (display_credit_i),
        .display_data_o   (display_data_o),
        .display_valid_o  (display_valid_o),
        .hsync_o          (hsync_o),
        .vsync_o          (vsync_o),
        .frame_ready_o    (frame_ready_o)
    );

    always #4 clk = ~clk;   // 8 ns period

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int random_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            rng_state = lfsr_next(rng_state);   // One step per bit
            r = (r << 1) | int'(rng_state[0]);
        end
        return r;
    endfunction

    task automatic check_color(input string name, input gfx_pkg::color_t exp,
                               input gfx_pkg::color_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s: expected %06h, actual %06h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            value_errors++;
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("Failure: %s", what);
    endtask

    task automatic write_pixel(input int x, input int y, input logic [31:0] data);
        @(negedge clk);
        pixel_x_i     = gfx_pkg::coord_t'(x);
        pixel_y_i     = gfx_pkg::coord_t'(y);
        pixel_data_i  = data;
        pixel_write_i = 1'b1;
        @(negedge clk);
        pixel_write_i = 1'b0;
    endtask

    // Start one frame, act as the credit-based sink, capture all pixels
    task automatic run_frame(input int extra_starts);
        int    cycles;
        int    valid_cnt;
        int    hs_cnt;
        int    hs_misplaced;
        int    vs_cnt;
        int    vs_index;
        int    vs_cycle;
        int    fr_cnt;
        int    fr_cycle;
        int    pending;
        int    extra_left;
        bit    ready_seen;
        string tag;
        {cycles, valid_cnt, hs_cnt, hs_misplaced, vs_cnt, fr_cnt, pending} = '0;
        {vs_index, vs_cycle, fr_cycle} = '0;
        ready_seen = 1'b0;
        extra_left = extra_starts;
        frames_run++;
        tag = $sformatf("frame %0d", frames_run);
        @(negedge clk);
        frame_start_i = 1'b1;
        @(negedge clk);
        frame_start_i = 1'b0;
        while (!(ready_seen && pending == 0)) begin
            if (cycles >= FRAME_TIMEOUT) begin
                report_failure($sformatf("%s did not finish within %0d cycles",
                                         tag, FRAME_TIMEOUT));
                timed_out = 1'b1;
                break;
            end
            if (display_valid_o) begin
                if (valid_cnt < PIXELS) frame_pix[valid_cnt] = display_data_o;
                valid_cnt++;
                pending++;           // Slot to hand back later
            end
            if (hsync_o) begin
                hs_cnt++;
                if (!display_valid_o || (valid_cnt % `GFX_SCAN_COLS) != 0) hs_misplaced++;
            end
            if (vsync_o) begin
                vs_cnt++;
                vs_index = valid_cnt;
                vs_cycle = cycles;
            end
            if (frame_ready_o) begin
                fr_cnt++;
                fr_cycle   = cycles;
                ready_seen = 1'b1;
            end
            display_credit_i = 1'b0;
            if (pending > 0 && random_bits(2) != 0) begin
                display_credit_i = 1'b1;
                pending--;
            end
            // Extra start lands mid-scan and must be ignored
            frame_start_i = 1'b0;
            if (extra_left > 0 && valid_cnt >= PIXELS / 4) begin
                frame_start_i = 1'b1;
                extra_left--;
            end
            @(negedge clk);
            cycles++;
        end
        display_credit_i = 1'b0;
        frame_start_i    = 1'b0;
        if (!timed_out) begin
            check_count({tag, " valid pixels"}, PIXELS, valid_cnt);
            check_count({tag, " hsync pulses"}, `GFX_SCAN_ROWS, hs_cnt);
            check_count({tag, " misplaced hsync"}, 0, hs_misplaced);
            check_count({tag, " vsync pulses"}, 1, vs_cnt);
            check_count({tag, " pixel index at vsync"}, PIXELS, vs_index);
            check_count({tag, " frame_ready pulses"}, 1, fr_cnt);
            check_count({tag, " frame_ready delay"}, 1, fr_cycle - vs_cycle);
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          x;
        int          y;
        byte         cmd;
        string       line;
        string       rest;
        logic [31:0] val;
        clk              = 1'b0;
        rst              = 1'b1;
        pixel_data_i     = '0;
        pixel_x_i        = '0;
        pixel_y_i        = '0;
        pixel_write_i    = 1'b0;
        frame_start_i    = 1'b0;
        display_credit_i = 1'b0;
        rng_state        = 16'd40814;
        {value_errors, other_errors, frames_run} = '0;
        timed_out        = 1'b0;
        repeat (2) @(posedge clk);   // Two rising edges in reset
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            report_failure({"cannot open stimulus file ", STIM_FILE});
        end else begin
            while (!$feof(fd) && !timed_out) begin
                if ($fgets(line, fd) == 0) break;
                cmd  = line.getc(0);
                rest = line.substr(1, line.len() - 1);
                case (cmd)
                    "W": begin
                        n = $sscanf(rest, "%d %d %h", x, y, val);
                        if (n != 3) report_failure({"bad write line: ", line});
                        else write_pixel(x, y, val);
                    end
                    "F": begin
                        n = $sscanf(rest, "%d", x);
                        if (n != 1) report_failure({"bad frame line: ", line});
                        else run_frame(x);
                    end
                    "C": begin
                        n = $sscanf(rest, "%d %d %h", x, y, val);
                        if (n != 3) begin
                            report_failure({"bad check line: ", line});
                        end else if (frames_run == 0) begin
                            report_failure("colour check comes before any frame");
                        end else if (x < 0 || x >= `GFX_SCAN_COLS ||
                                     y < 0 || y >= `GFX_SCAN_ROWS) begin
                            report_failure({"check point outside the scanned area: ", line});
                        end else begin
                            check_color($sformatf("frame %0d pixel (%0d,%0d)", frames_run, x, y),
                                        gfx_pkg::color_t'(val),
                                        frame_pix[y * `GFX_SCAN_COLS + x]);
                        end
                    end
                    "#", " ", "\n", "\r": ;   // Comment or blank
                    default: report_failure({"unknown stimulus line: ", line});
                endcase
            end
            $fclose(fd);
            if (frames_run == 0) report_failure("stimulus holds no frame");
        end

        $display("Errors: %0d value, %0d other, %0d assertion",
                 value_errors, other_errors, dut0.sva0.sva_errors);
        if (value_errors + other_errors + dut0.sva0.sva_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+include
design/gfx_pkg.sv
design/gfx_if.sv
design/pattern_lfsr.sv
design/frame_buffer.sv
design/raster_scan.sv
design/trojan_slave_select.sv
design/palette_colorizer.sv
design/gfx_host_top.sv
verif/gfx_host_sva.sv
verif/gfx_host_tb.sv

// File: Makefile
# Verilator build and run for the graphics host testbench
# Override any variable on the command line, e.g. make run LOG=run2.log

VERILATOR ?= verilator
TOP       ?= gfx_host_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Simulation finished: FAIL
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Result: failing run"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Result: run ended early"; exit 1; fi
	@echo "Result: passing run"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/gfx_stimulus.txt
# W x y data : frame-buffer write, x and y decimal, data hex
# F n : scan one frame with n extra frame starts mid-scan ; C x y colour : expected colour, hex
# Frame 1, reset contents, pattern one step short of the key
F 0
C 0 0 ADBFDE
C 5 5 ADBF83
C 20 20 ADBF72
C 3 7 ADBFC1
C 31 23 ADBFDD
# Frame 2, second step hits the key, diagonal colours carry nibble C
F 0
C 0 0 ADBFD2
C 5 5 ADBF8F
C 20 20 ADBF7E
C 3 7 ADBFC1
C 4 7 ADBFC2
C 31 23 ADBFDD
# Writes, x of 37 wraps to column 5
W 3 7 12345600
W 10 2 CAFE0080
W 6 6 000000FF
W 31 23 FFFFFF10
W 37 1 00000001
# Frame 3, key gone, one frame start during the scan is ignored
F 1
C 3 7 ADBEEF
C 10 2 ADBF6F
C 6 6 ADBFEE
C 31 23 ADBEFF
C 5 1 ADBEF0
C 4 7 ADBFC2
C 0 0 ADBFDE
C 20 20 ADBF72
